/* verilog/mem_defines.svh */
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// Data and address width
`define XLEN 32

// Register number width
`define REG_ADDR_W 5

// Bytes per data word
`define BYTE_LANES 4

// Stages from acceptance to writeback
`define MEM_STAGES 3

`endif

/* verilog/rv_isa_pkg.sv */
package rv_isa_pkg;

    //////////////////////////////
    // Load/store width, funct3 field
    //////////////////////////////

    typedef enum logic [2:0] {
        W_BYTE  = 3'b000,
        W_HALF  = 3'b001,
        W_WORD  = 3'b010,
        W_UBYTE = 3'b100,
        W_UHALF = 3'b101
    } width_e;

    //////////////////////////////
    // Operation kind from execute
    //////////////////////////////

    typedef enum logic [1:0] {
        KIND_NONE  = 2'b00,
        KIND_ALU   = 2'b01,
        KIND_LOAD  = 2'b10,
        KIND_STORE = 2'b11
    } op_kind_e;

endpackage

/* verilog/mem_pipe_pkg.sv */
`include "mem_defines.svh"

package mem_pipe_pkg;

    // Executed operation handed over by the execute stage
    typedef struct packed {
        rv_isa_pkg::op_kind_e   kind;
        rv_isa_pkg::width_e     width;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       result;
        logic [`XLEN-1:0]       store_data;
    } ex_op_t;

    // Tag carried alongside each memory stage
    typedef struct packed {
        rv_isa_pkg::op_kind_e   kind;
        rv_isa_pkg::width_e     width;
        logic [`REG_ADDR_W-1:0] rd;
    } stage_meta_t;

    typedef enum logic [1:0] {
        CMD_IDLE  = 2'b00,
        CMD_READ  = 2'b01,
        CMD_WRITE = 2'b10
    } cache_cmd_e;

    // Word-aligned data cache request
    typedef struct packed {
        cache_cmd_e             cmd;
        logic [`XLEN-1:0]       addr;
        logic [`BYTE_LANES-1:0] byte_en;
        logic [`XLEN-1:0]       wdata;
    } cache_req_t;

    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
    } reg_write_t;

endpackage

/* verilog/pipe_ctrl.sv */
`include "mem_defines.svh"

module pipe_ctrl (
    input  logic                       CLK,
    input  logic                       rst,
    input  logic                       in_valid,
    input  rv_isa_pkg::op_kind_e       in_kind,
    input  rv_isa_pkg::op_kind_e       stage_kind,
    input  logic                       cache_ready,
    output logic                       in_ready,
    output logic                       advance,
    output mem_pipe_pkg::cache_cmd_e   cache_cmd,
    output logic [`MEM_STAGES-1:0]     stage_valid,
    output logic                       wb_valid
);

    // The cache is the only source of back-pressure
    assign advance  = cache_ready;
    assign in_ready = cache_ready;

    always_ff @(posedge CLK)
    begin
        if (rst)
            stage_valid <= '0;
        else if (advance)
            stage_valid <= {stage_valid[`MEM_STAGES-2:0], in_valid};
    end

    always_comb
    begin
        cache_cmd = mem_pipe_pkg::CMD_IDLE;
        if (in_valid)
        begin
            if (in_kind == rv_isa_pkg::KIND_LOAD)
                cache_cmd = mem_pipe_pkg::CMD_READ;
            else if (in_kind == rv_isa_pkg::KIND_STORE)
                cache_cmd = mem_pipe_pkg::CMD_WRITE;
        end
    end

    // Only ALU results and loads reach the register file
    assign wb_valid = stage_valid[`MEM_STAGES-1] & advance &
                      ((stage_kind == rv_isa_pkg::KIND_ALU) ||
                       (stage_kind == rv_isa_pkg::KIND_LOAD));

endmodule

/* verilog/store_align.sv */
`include "mem_defines.svh"

module store_align (
    input  mem_pipe_pkg::ex_op_t     op,
    input  mem_pipe_pkg::cache_cmd_e cmd,
    output mem_pipe_pkg::cache_req_t req
);

    logic [1:0]             offset;
    logic [`BYTE_LANES-1:0] byte_en;

    assign offset = op.result[1:0];

    always_comb
    begin
        byte_en = '0;
        if (cmd != mem_pipe_pkg::CMD_IDLE)
        begin
            case (op.width)
                rv_isa_pkg::W_WORD:
                    byte_en = 4'b1111;
                rv_isa_pkg::W_HALF, rv_isa_pkg::W_UHALF:
                begin
                    // Half crossing the word boundary gets no lanes
                    case (offset)
                        2'b00:   byte_en = 4'b0011;
                        2'b01:   byte_en = 4'b0110;
                        2'b10:   byte_en = 4'b1100;
                        default: byte_en = 4'b0000;
                    endcase
                end
                rv_isa_pkg::W_BYTE, rv_isa_pkg::W_UBYTE:
                    byte_en = 4'b0001 << offset;
                default:
                    byte_en = 4'b0000;
            endcase
        end
    end

    assign req.cmd     = cmd;
    assign req.addr    = {op.result[`XLEN-1:2], 2'b00};
    assign req.byte_en = byte_en;
    assign req.wdata   = op.store_data << {offset, 3'b000};

endmodule

/* verilog/stage_shift.sv */
module stage_shift #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 3
) (
    input  logic     CLK,
    input  logic     rst,
    input  logic     advance,
    input  payload_t d,
    output payload_t q [DEPTH]
);

    // q[0] is the youngest stage
    always_ff @(posedge CLK)
    begin
        if (rst)
        begin
            for (int i = 0; i < DEPTH; i++)
                q[i] <= '0;
        end
        else if (advance)
        begin
            q[0] <= d;
            for (int i = 1; i < DEPTH; i++)
                q[i] <= q[i-1];
        end
    end

endmodule

/* verilog/load_align.sv */
`include "mem_defines.svh"

module load_align (
    input  mem_pipe_pkg::stage_meta_t meta,
    input  logic [`XLEN-1:0]          result,
    input  logic [`XLEN-1:0]          rdata,
    output mem_pipe_pkg::reg_write_t  wb
);

    logic [`XLEN-1:0] shifted;
    logic             half_ok;

    // Addressed byte or half moved down to lane 0
    assign shifted = rdata >> {result[1:0], 3'b000};
    assign half_ok = (result[1:0] != 2'b11);

    always_comb
    begin
        wb.rd   = (meta.kind == rv_isa_pkg::KIND_STORE) ? '0 : meta.rd;
        wb.data = result;
        if (meta.kind == rv_isa_pkg::KIND_LOAD)
        begin
            case (meta.width)
                rv_isa_pkg::W_BYTE:
                    wb.data = {{(`XLEN-8){shifted[7]}}, shifted[7:0]};
                rv_isa_pkg::W_UBYTE:
                    wb.data = {{(`XLEN-8){1'b0}}, shifted[7:0]};
                rv_isa_pkg::W_HALF:
                begin
                    if (half_ok)
                        wb.data = {{(`XLEN-16){shifted[15]}}, shifted[15:0]};
                    else
                        wb.data = '0;
                end
                rv_isa_pkg::W_UHALF:
                begin
                    if (half_ok)
                        wb.data = {{(`XLEN-16){1'b0}}, shifted[15:0]};
                    else
                        wb.data = '0;
                end
                default:
                    wb.data = rdata;
            endcase
        end
    end

endmodule

/* verilog/fwd_select.sv */
`include "mem_defines.svh"

module fwd_select (
    input  logic                      CLK,
    input  logic                      rst,
    input  logic [`REG_ADDR_W-1:0]    rs,
    input  mem_pipe_pkg::stage_meta_t metas [`MEM_STAGES],
    input  logic [`XLEN-1:0]          results [`MEM_STAGES],
    input  logic                      wb_valid,
    input  mem_pipe_pkg::reg_write_t  wb,
    input  logic [`MEM_STAGES-1:0]    stage_valid,
    output logic                      hit,
    output logic                      busy,
    output logic [`XLEN-1:0]          data
);

    mem_pipe_pkg::reg_write_t last_wb;
    logic                     last_valid;

    always_ff @(posedge CLK)
    begin
        if (rst)
            last_valid <= 1'b0;
        else if (wb_valid)
            last_valid <= 1'b1;
    end

    always_ff @(posedge CLK)
    begin
        if (wb_valid)
            last_wb <= wb;
    end

    // Oldest first so the youngest match wins
    always_comb
    begin
        hit  = 1'b0;
        busy = 1'b0;
        data = '0;
        if (last_valid && (rs != '0) && (last_wb.rd == rs))
        begin
            hit  = 1'b1;
            data = last_wb.data;
        end
        for (int i = `MEM_STAGES-1; i >= 0; i--)
        begin
            if (stage_valid[i] && (rs != '0) && (metas[i].rd == rs) &&
                ((metas[i].kind == rv_isa_pkg::KIND_ALU) ||
                 (metas[i].kind == rv_isa_pkg::KIND_LOAD)))
            begin
                hit  = 1'b1;
                busy = 1'b0;
                if (i == `MEM_STAGES-1)
                begin
                    // Load data only good while the cache is ready
                    data = wb.data;
                    busy = (metas[i].kind == rv_isa_pkg::KIND_LOAD) && !wb_valid;
                end
                else if (metas[i].kind == rv_isa_pkg::KIND_LOAD)
                begin
                    busy = 1'b1;
                    data = '0;
                end
                else
                    data = results[i];
            end
        end
    end

endmodule

/* verilog/mem_access_unit.sv */
`include "mem_defines.svh"

module mem_access_unit (
    input  logic                      CLK,
    input  logic                      rst,

    // Execute stage handshake
    input  logic                      in_valid,
    input  mem_pipe_pkg::ex_op_t      in_op,
    output logic                      in_ready,

    // Data cache
    output mem_pipe_pkg::cache_req_t  cache_req,
    input  logic                      cache_ready,
    input  logic [`XLEN-1:0]          cache_rdata,

    // Register file write port
    output logic                      wb_valid,
    output mem_pipe_pkg::reg_write_t  wb,

    // Operand forwarding query
    input  logic [`REG_ADDR_W-1:0]    fwd_rs,
    output logic                      fwd_hit,
    output logic                      fwd_busy,
    output logic [`XLEN-1:0]          fwd_data
);

    logic                      advance;
    mem_pipe_pkg::cache_cmd_e  cache_cmd;
    logic [`MEM_STAGES-1:0]    stage_valid;
    mem_pipe_pkg::stage_meta_t in_meta;
    mem_pipe_pkg::stage_meta_t metas [`MEM_STAGES];
    logic [`XLEN-1:0]          results [`MEM_STAGES];

    assign in_meta.kind  = in_op.kind;
    assign in_meta.width = in_op.width;
    assign in_meta.rd    = in_op.rd;

    //////////////////////////////
    // Control and cache request
    //////////////////////////////

    pipe_ctrl u_ctrl (
        .CLK         (CLK),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_kind     (in_op.kind),
        .stage_kind  (metas[`MEM_STAGES-1].kind),
        .cache_ready (cache_ready),
        .in_ready    (in_ready),
        .advance     (advance),
        .cache_cmd   (cache_cmd),
        .stage_valid (stage_valid),
        .wb_valid    (wb_valid)
    );

    store_align u_store (
        .op  (in_op),
        .cmd (cache_cmd),
        .req (cache_req)
    );

    //////////////////////////////
    // Memory stages
    //////////////////////////////

    stage_shift #(
        .payload_t (mem_pipe_pkg::stage_meta_t),
        .DEPTH     (`MEM_STAGES)
    ) u_meta_pipe (
        .CLK     (CLK),
        .rst     (rst),
        .advance (advance),
        .d       (in_meta),
        .q       (metas)
    );

    stage_shift #(
        .payload_t (logic [`XLEN-1:0]),
        .DEPTH     (`MEM_STAGES)
    ) u_result_pipe (
        .CLK     (CLK),
        .rst     (rst),
        .advance (advance),
        .d       (in_op.result),
        .q       (results)
    );

    //////////////////////////////
    // Writeback and forwarding
    //////////////////////////////

    load_align u_load (
        .meta   (metas[`MEM_STAGES-1]),
        .result (results[`MEM_STAGES-1]),
        .rdata  (cache_rdata),
        .wb     (wb)
    );

    fwd_select u_fwd (
        .CLK         (CLK),
        .rst         (rst),
        .rs          (fwd_rs),
        .metas       (metas),
        .results     (results),
        .wb_valid    (wb_valid),
        .wb          (wb),
        .stage_valid (stage_valid),
        .hit         (fwd_hit),
        .busy        (fwd_busy),
        .data        (fwd_data)
    );

endmodule

/* verification/data_cache_model.sv */
`include "mem_defines.svh"

module data_cache_model (
    input  logic                     CLK,
    input  logic                     rst,
    input  mem_pipe_pkg::cache_req_t req,
    input  logic [7:0]               stall_pattern,
    output logic                     ready,
    output logic [`XLEN-1:0]         rdata
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WORDS = 256;

    logic [`XLEN-1:0] mem [WORDS];
    logic [`XLEN-1:0] read_pipe [`MEM_STAGES];
    logic [2:0]       phase;
    logic [7:0]       idx;

    // Fill value for one byte, from all ten address bits
    function automatic logic [7:0] fill_byte(logic [9:0] a);
        return a[7:0] ^ {a[9:8], a[9:8], a[9:8], a[9:8]};
    endfunction

    initial
    begin
        for (int w = 0; w < WORDS; w++)
        begin
            for (int l = 0; l < `BYTE_LANES; l++)
                mem[w][8*l +: 8] = fill_byte(10'(4 * w + l));
        end
    end

    assign idx   = req.addr[9:2];
    assign ready = !stall_pattern[phase];
    assign rdata = read_pipe[`MEM_STAGES-1];

    always_ff @(posedge CLK)
    begin
        if (rst)
            phase <= '0;
        else
            phase <= phase + 3'd1;
    end

    // Read data captured at the request, handed out three advances later
    always_ff @(posedge CLK)
    begin
        if (ready)
        begin
            read_pipe[0] <= (req.cmd == mem_pipe_pkg::CMD_READ) ? mem[idx] : '0;
            for (int i = 1; i < `MEM_STAGES; i++)
                read_pipe[i] <= read_pipe[i-1];
            if (req.cmd == mem_pipe_pkg::CMD_WRITE)
            begin
                for (int l = 0; l < `BYTE_LANES; l++)
                begin
                    if (req.byte_en[l])
                        mem[idx][8*l +: 8] <= req.wdata[8*l +: 8];
                end
            end
        end
    end

endmodule

/* verification/tb_mem_access.sv */
`include "mem_defines.svh"

module tb_mem_access;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int T1_OPS = 4;
    localparam int T2_OPS = 24;
    localparam int T3_OPS = 8;
    localparam int T4_OPS = 12;
    localparam int T5_OPS = 3;
    localparam int T6_OPS = 200;
    localparam int WATCHDOG_CYCLES =
        (T1_OPS + T2_OPS + T3_OPS + T4_OPS + T5_OPS + T6_OPS) * 20;

    logic                      CLK = 1'b0;
    logic                      rst;
    logic                      in_valid;
    mem_pipe_pkg::ex_op_t      in_op;
    logic                      in_ready;
    mem_pipe_pkg::cache_req_t  cache_req;
    logic                      cache_ready;
    logic [`XLEN-1:0]          cache_rdata;
    logic                      wb_valid;
    mem_pipe_pkg::reg_write_t  wb;
    logic [`REG_ADDR_W-1:0]    fwd_rs;
    logic                      fwd_hit;
    logic                      fwd_busy;
    logic [`XLEN-1:0]          fwd_data;
    logic [7:0]                stall_pattern;

    int    seed = 86254;
    string test_name = "reset";

    // Reference memory and expected writebacks in issue order
    logic [7:0]               ref_mem [1024];
    mem_pipe_pkg::reg_write_t exp_q [$];
    int                       exp_cycle_q [$];
    int                       cycle_count = 0;
    logic [2:0]               tb_phase;
    logic                     no_stalls = 1'b1;

    always #5 CLK = ~CLK;

    mem_access_unit uut (
        .CLK         (CLK),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_op       (in_op),
        .in_ready    (in_ready),
        .cache_req   (cache_req),
        .cache_ready (cache_ready),
        .cache_rdata (cache_rdata),
        .wb_valid    (wb_valid),
        .wb          (wb),
        .fwd_rs      (fwd_rs),
        .fwd_hit     (fwd_hit),
        .fwd_busy    (fwd_busy),
        .fwd_data    (fwd_data)
    );

    data_cache_model u_cache (
        .CLK           (CLK),
        .rst           (rst),
        .req           (cache_req),
        .stall_pattern (stall_pattern),
        .ready         (cache_ready),
        .rdata         (cache_rdata)
    );

    // Cycle count and the cache's stall phase as seen by the testbench
    always @(posedge CLK)
    begin
        cycle_count <= cycle_count + 1;
        if (rst)
            tb_phase <= '0;
        else
            tb_phase <= tb_phase + 3'd1;
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic check_equal(string what, logic [31:0] exp, logic [31:0] act);
        assert (act === exp)
        else
        begin
            $display("ERROR %s %s expected %h actual %h", test_name, what, exp, act);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic report_failure(string msg);
        $display("%s: %s", test_name, msg);
        $display("Test failed");
        $fatal(1);
    endtask

    // Writeback and handshake monitor
    always @(negedge CLK)
    begin
        mem_pipe_pkg::reg_write_t exp_wb;
        int                       exp_cycle;
        #1;
        if (!rst)
        begin
            check_equal("in_ready", {31'b0, !stall_pattern[tb_phase]}, {31'b0, in_ready});
            assert (in_ready || !wb_valid)
            else
                report_failure("writeback while the cache is stalled");
            if (wb_valid)
            begin
                assert (exp_q.size() > 0)
                else
                    report_failure("writeback with none expected");
                exp_wb    = exp_q.pop_front();
                exp_cycle = exp_cycle_q.pop_front();
                check_equal("wb rd", {27'b0, exp_wb.rd}, {27'b0, wb.rd});
                check_equal("wb data", exp_wb.data, wb.data);
                if (no_stalls)
                    check_equal("wb cycle", exp_cycle, cycle_count);
            end
        end
    end

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic logic [7:0] fill_byte(logic [9:0] a);
        return a[7:0] ^ {a[9:8], a[9:8], a[9:8], a[9:8]};
    endfunction

    function automatic logic [3:0] lanes_for(rv_isa_pkg::width_e w, logic [1:0] off);
        case (w)
            rv_isa_pkg::W_WORD:
                return 4'b1111;
            rv_isa_pkg::W_HALF, rv_isa_pkg::W_UHALF:
                return (off == 2'd3) ? 4'b0000 : 4'b0011 << off;
            default:
                return 4'b0001 << off;
        endcase
    endfunction

    function automatic logic [31:0] load_value(rv_isa_pkg::width_e w, logic [9:0] a);
        logic [7:0]  b;
        logic [15:0] h;
        b = ref_mem[a];
        h = {ref_mem[a + 10'd1], ref_mem[a]};
        case (w)
            rv_isa_pkg::W_BYTE:
                return {{24{b[7]}}, b};
            rv_isa_pkg::W_UBYTE:
                return {24'b0, b};
            rv_isa_pkg::W_HALF:
                return (a[1:0] == 2'd3) ? 32'b0 : {{16{h[15]}}, h};
            rv_isa_pkg::W_UHALF:
                return (a[1:0] == 2'd3) ? 32'b0 : {16'b0, h};
            default:
                return {ref_mem[{a[9:2], 2'd3}], ref_mem[{a[9:2], 2'd2}],
                        ref_mem[{a[9:2], 2'd1}], ref_mem[{a[9:2], 2'd0}]};
        endcase
    endfunction

    function automatic mem_pipe_pkg::ex_op_t make_op(rv_isa_pkg::op_kind_e kind,
                                                     rv_isa_pkg::width_e w,
                                                     logic [4:0] rd,
                                                     logic [31:0] result,
                                                     logic [31:0] sd);
        mem_pipe_pkg::ex_op_t op;
        op.kind       = kind;
        op.width      = w;
        op.rd         = rd;
        op.result     = result;
        op.store_data = sd;
        return op;
    endfunction

    // Cache request of the offered operation
    task automatic check_request(mem_pipe_pkg::ex_op_t op);
        logic [3:0] lanes;
        logic [1:0] off;
        off   = op.result[1:0];
        lanes = lanes_for(op.width, off);
        if (op.kind == rv_isa_pkg::KIND_ALU)
        begin
            check_equal("cmd", mem_pipe_pkg::CMD_IDLE, cache_req.cmd);
            check_equal("byte_en", 0, cache_req.byte_en);
        end
        else
        begin
            check_equal("cmd", (op.kind == rv_isa_pkg::KIND_LOAD) ?
                        mem_pipe_pkg::CMD_READ : mem_pipe_pkg::CMD_WRITE, cache_req.cmd);
            check_equal("addr", {op.result[31:2], 2'b00}, cache_req.addr);
            check_equal("byte_en", lanes, cache_req.byte_en);
            if (op.kind == rv_isa_pkg::KIND_STORE)
            begin
                for (int l = 0; l < 4; l++)
                begin
                    if (lanes[l])
                        check_equal("wdata lane", op.store_data[8*(l-off) +: 8],
                                    cache_req.wdata[8*l +: 8]);
                end
            end
        end
    endtask

    // Update the reference and queue the expected writeback
    task automatic expect_result(mem_pipe_pkg::ex_op_t op);
        mem_pipe_pkg::reg_write_t e;
        logic [3:0]               lanes;
        logic [1:0]               off;
        off  = op.result[1:0];
        e.rd = op.rd;
        if (op.kind == rv_isa_pkg::KIND_STORE)
        begin
            lanes = lanes_for(op.width, off);
            for (int l = 0; l < 4; l++)
            begin
                if (lanes[l])
                    ref_mem[{op.result[9:2], 2'(l)}] = op.store_data[8*(l-off) +: 8];
            end
        end
        else
        begin
            if (op.kind == rv_isa_pkg::KIND_LOAD)
                e.data = load_value(op.width, op.result[9:0]);
            else
                e.data = op.result;
            exp_q.push_back(e);
            exp_cycle_q.push_back(cycle_count + 3);
        end
    endtask

    //////////////////////////////
    // Drivers
    //////////////////////////////

    // Offer one operation and return after its accept edge
    task automatic send(mem_pipe_pkg::ex_op_t op);
        int waited;
        waited = 0;
        @(negedge CLK);
        in_valid = 1'b1;
        in_op    = op;
        #1;
        while (!in_ready)
        begin
            waited++;
            if (waited > 100)
                report_failure("operation never accepted");
            @(negedge CLK);
            #1;
        end
        check_request(op);
        expect_result(op);
        @(posedge CLK);
    endtask

    task automatic set_stalls(logic [7:0] pattern);
        @(negedge CLK);
        in_valid      = 1'b0;
        stall_pattern = pattern;
    endtask

    task automatic check_memory();
        for (int w = 0; w < 256; w++)
            check_equal("memory word", {ref_mem[4*w+3], ref_mem[4*w+2],
                        ref_mem[4*w+1], ref_mem[4*w]}, u_cache.mem[w]);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(negedge CLK);
        in_valid = 1'b0;
        while (exp_q.size() > 0)
        begin
            waited++;
            if (waited > 200)
                report_failure("pipeline did not drain");
            @(negedge CLK);
        end
        repeat (2) @(negedge CLK);
        check_memory();
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////

    task automatic store_then_load();
        test_name = "store_then_load";
        send(make_op(rv_isa_pkg::KIND_STORE, rv_isa_pkg::W_WORD, 5'd9, 32'h40, 32'hdeadbeef));
        send(make_op(rv_isa_pkg::KIND_LOAD, rv_isa_pkg::W_WORD, 5'd3, 32'h40, 32'h0));
        send(make_op(rv_isa_pkg::KIND_ALU, rv_isa_pkg::W_WORD, 5'd4, 32'h1234, 32'h0));
        send(make_op(rv_isa_pkg::KIND_LOAD, rv_isa_pkg::W_WORD, 5'd6, 32'h40, 32'h0));
        drain();
    endtask

    task automatic sub_word_access();
        test_name = "sub_word_access";
        for (int off = 0; off < 4; off++)
        begin
            send(make_op(rv_isa_pkg::KIND_STORE, rv_isa_pkg::W_BYTE, 5'd0,
                         32'h80 + off, $random(seed)));
            send(make_op(rv_isa_pkg::KIND_STORE, rv_isa_pkg::W_HALF, 5'd0,
                         32'ha0 + off, $random(seed)));
            send(make_op(rv_isa_pkg::KIND_LOAD, rv_isa_pkg::W_BYTE, 5'd1, 32'h80 + off, 0));
            send(make_op(rv_isa_pkg::KIND_LOAD, rv_isa_pkg::W_UBYTE, 5'd2, 32'h80 + off, 0));
            send(make_op(rv_isa_pkg::KIND_LOAD, rv_isa_pkg::W_HALF, 5'd3, 32'ha0 + off, 0));
            send(make_op(rv_isa_pkg::KIND_LOAD, rv_isa_pkg::W_UHALF, 5'd4, 32'ha0 + off, 0));
        end
        drain();
    endtask

    task automatic alu_stream();
        test_name = "alu_stream";
        for (int i = 1; i <= T3_OPS; i++)
            send(make_op(rv_isa_pkg::KIND_ALU, rv_isa_pkg::W_WORD, 5'(i), $random(seed), 0));
        drain();
    endtask

    task automatic stalled_access();
        test_name = "stalled_access";
        no_stalls = 1'b0;
        set_stalls(8'b0110_1001);
        for (int i = 0; i < T4_OPS / 2; i++)
        begin
            send(make_op(rv_isa_pkg::KIND_STORE, rv_isa_pkg::W_WORD, 5'd0,
                         32'h100 + 4 * i, $random(seed)));
            send(make_op(rv_isa_pkg::KIND_LOAD, rv_isa_pkg::W_WORD, 5'(10 + i),
                         32'h100 + 4 * i, 0));
        end
        drain();
        set_stalls(8'h00);
        no_stalls = 1'b1;
    endtask

    task automatic forwarding();
        logic [31:0] exp_load;
        test_name = "forwarding";
        send(make_op(rv_isa_pkg::KIND_ALU, rv_isa_pkg::W_WORD, 5'd5, 32'hcafe0005, 0));
        @(negedge CLK);
        in_valid = 1'b0;
        fwd_rs   = 5'd5;
        #1;
        check_equal("alu hit", 1, fwd_hit);
        check_equal("alu busy", 0, fwd_busy);
        check_equal("alu data", 32'hcafe0005, fwd_data);
        drain();
        exp_load = load_value(rv_isa_pkg::W_HALF, 10'h0a2);
        send(make_op(rv_isa_pkg::KIND_LOAD, rv_isa_pkg::W_HALF, 5'd7, 32'ha2, 0));
        @(negedge CLK);
        in_valid = 1'b0;
        fwd_rs   = 5'd7;
        for (int s = 0; s < 2; s++)
        begin
            #1;
            check_equal("load hit", 1, fwd_hit);
            check_equal("load busy", 1, fwd_busy);
            @(negedge CLK);
        end
        #1;
        check_equal("last stage busy", 0, fwd_busy);
        check_equal("last stage data", exp_load, fwd_data);
        drain();
        #1;
        check_equal("written hit", 1, fwd_hit);
        check_equal("written data", exp_load, fwd_data);
        send(make_op(rv_isa_pkg::KIND_ALU, rv_isa_pkg::W_WORD, 5'd0, 32'h1234, 0));
        @(negedge CLK);
        in_valid = 1'b0;
        fwd_rs   = 5'd0;
        #1;
        check_equal("x0 in flight", 0, fwd_hit);
        drain();
        #1;
        check_equal("x0 written", 0, fwd_hit);
    endtask

    task automatic random_mix();
        rv_isa_pkg::width_e   widths [5];
        rv_isa_pkg::op_kind_e kind;
        rv_isa_pkg::width_e   w;
        logic [31:0]          addr;
        widths = '{rv_isa_pkg::W_BYTE, rv_isa_pkg::W_HALF, rv_isa_pkg::W_WORD,
                   rv_isa_pkg::W_UBYTE, rv_isa_pkg::W_UHALF};
        test_name = "random_mix";
        no_stalls = 1'b0;
        for (int n = 0; n < T6_OPS; n++)
        begin
            // Stall slot 0 is kept open so the cache always makes progress
            if (n % 40 == 0)
                set_stalls(8'($random(seed)) & 8'hfe);
            kind = rv_isa_pkg::op_kind_e'(2'({$random(seed)} % 3 + 1));
            w    = widths[{$random(seed)} % 5];
            addr = {$random(seed)} & 32'h3ff;
            if (w == rv_isa_pkg::W_WORD)
                addr[1:0] = 2'b00;
            send(make_op(kind, w, 5'($random(seed)), addr, $random(seed)));
        end
        drain();
        set_stalls(8'h00);
        no_stalls = 1'b1;
    endtask

    //////////////////////////////
    // Sequence and watchdog
    //////////////////////////////

    initial
    begin
        rst           = 1'b1;
        in_valid      = 1'b0;
        in_op         = '0;
        fwd_rs        = '0;
        stall_pattern = 8'h00;
        for (int a = 0; a < 1024; a++)
            ref_mem[a] = fill_byte(10'(a));
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        rst = 1'b0;
        #1;
        check_equal("wb_valid after reset", 0, wb_valid);
        check_equal("cmd after reset", mem_pipe_pkg::CMD_IDLE, cache_req.cmd);
        check_equal("fwd_hit after reset", 0, fwd_hit);

        store_then_load();
        sub_word_access();
        alu_stream();
        stalled_access();
        forwarding();
        random_mix();

        $display("Test passed");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge CLK);
        $display("Watchdog timeout in %s", test_name);
        $display("Test failed");
        $fatal(1);
    end

endmodule

/* sim.f */
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/mem_pipe_pkg.sv
verilog/pipe_ctrl.sv
verilog/store_align.sv
verilog/stage_shift.sv
verilog/load_align.sv
verilog/fwd_select.sv
verilog/mem_access_unit.sv
verification/data_cache_model.sv
verification/tb_mem_access.sv

/* run.sh */
#!/bin/sh
# Build and run the memory access testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module tb_mem_access -o tb_mem_access
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_mem_access)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Test passed"; then
    exit 0
fi
exit 1
